// File: src/tetris_pkg.sv
`default_nettype none

package tetris_pkg;

    // action codes, lower code wins arbitration
    typedef enum logic [2:0] {
        act_none      = 3'd0,
        act_hard_drop = 3'd1,
        act_soft_drop = 3'd2,
        act_move_r    = 3'd3,
        act_move_l    = 3'd4,
        act_rotate_r  = 3'd5,
        act_rotate_l  = 3'd6
    } action_t;

    localparam int num_actions = 6;

    // bit i belongs to action code i+1
    typedef logic [num_actions-1:0] action_vec_t;

    typedef enum logic [1:0] {
        scr_title  = 2'd0,
        scr_sprint = 2'd1,
        scr_end    = 2'd2
    } screen_t;

    // keys are active low, rotate_mode high selects rotate
    typedef struct packed {
        logic key_left;
        logic key_right;
        logic key_soft;
        logic key_hard;
        logic key_start;
        logic rotate_mode;
    } buttons_t;

    typedef struct packed {
        logic [4:0] hours;
        logic [5:0] minutes;
        logic [5:0] seconds;
        logic [3:0] deciseconds;
        logic [3:0] centiseconds;
        logic [3:0] milliseconds;
    } play_time_t;

    typedef logic [5:0] lines_t;

    localparam int das_delay_default    = 16;
    localparam int arr_period_default   = 6;
    localparam int tick_cycles_default  = 50_000;
    localparam int sprint_lines_default = 40;

endpackage

`default_nettype wire

// File: src/action_repeat.sv
`default_nettype none
`timescale 1ns/100ps

module action_repeat #(
    parameter int DAS_DELAY  = tetris_pkg::das_delay_default,
    parameter int ARR_PERIOD = tetris_pkg::arr_period_default,
    parameter bit REPEAT_EN  = 1'b1
) (
    input  logic clk,
    input  logic rst_l,
    input  logic held,
    output logic pulse
);

    localparam int CNT_MAX = (DAS_DELAY > ARR_PERIOD) ? DAS_DELAY : ARR_PERIOD;
    localparam int CNT_W   = $clog2(CNT_MAX + 1);

    typedef enum logic [1:0] {
        st_idle,
        st_delay,
        st_repeat
    } state_t;

    state_t           state;
    state_t           state_n;
    logic [CNT_W-1:0] cnt;
    logic [CNT_W-1:0] cnt_n;
    logic             expired;

    // without repeat the counter never expires, one pulse per press
    assign expired = REPEAT_EN && (cnt == '0);

    always_comb begin
        state_n = state;
        cnt_n   = cnt;
        pulse   = 1'b0;
        case (state)
            st_idle: begin
                if (held) begin
                    pulse   = 1'b1;
                    state_n = st_delay;
                    cnt_n   = CNT_W'(DAS_DELAY - 1);
                end
            end
            st_delay, st_repeat: begin
                if (!held) begin
                    state_n = st_idle;
                end else if (expired) begin
                    pulse   = 1'b1;
                    state_n = st_repeat;
                    cnt_n   = CNT_W'(ARR_PERIOD - 1);
                end else if (cnt != '0) begin
                    cnt_n = cnt - 1'b1;
                end
            end
            default: begin
                state_n = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            state <= st_idle;
            cnt   <= '0;
        end else begin
            state <= state_n;
            cnt   <= cnt_n;
        end
    end

endmodule

`default_nettype wire

// File: src/action_inputs.sv
`default_nettype none
`timescale 1ns/100ps

module action_inputs #(
    parameter int DAS_DELAY  = tetris_pkg::das_delay_default,
    parameter int ARR_PERIOD = tetris_pkg::arr_period_default
) (
    input  logic                    clk,
    input  logic                    rst_l,
    input  tetris_pkg::buttons_t    buttons,
    output tetris_pkg::action_vec_t pulses,
    output logic                    start_press
);

    tetris_pkg::buttons_t    sync_q1;
    tetris_pkg::buttons_t    sync_q2;
    tetris_pkg::action_vec_t held;
    logic                    start_held;
    logic                    start_prev;

    // two-flop synchronizer, idle level is all ones
    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            sync_q1    <= '1;
            sync_q2    <= '1;
            start_prev <= 1'b0;
        end else begin
            sync_q1    <= buttons;
            sync_q2    <= sync_q1;
            start_prev <= start_held;
        end
    end

    // left/right steer to move or rotate by the mode switch
    always_comb begin
        held[int'(tetris_pkg::act_hard_drop) - 1] = !sync_q2.key_hard;
        held[int'(tetris_pkg::act_soft_drop) - 1] = !sync_q2.key_soft;
        held[int'(tetris_pkg::act_move_r) - 1]    = !sync_q2.rotate_mode && !sync_q2.key_right;
        held[int'(tetris_pkg::act_move_l) - 1]    = !sync_q2.rotate_mode && !sync_q2.key_left;
        held[int'(tetris_pkg::act_rotate_r) - 1]  = sync_q2.rotate_mode && !sync_q2.key_right;
        held[int'(tetris_pkg::act_rotate_l) - 1]  = sync_q2.rotate_mode && !sync_q2.key_left;
    end

    assign start_held  = !sync_q2.key_start;
    assign start_press = start_held && !start_prev;

    for (genvar i = 0; i < tetris_pkg::num_actions; i++) begin : g_repeat
        action_repeat #(
            .DAS_DELAY  (DAS_DELAY),
            .ARR_PERIOD (ARR_PERIOD),
            .REPEAT_EN  (i != int'(tetris_pkg::act_hard_drop) - 1)
        ) u_repeat (
            .clk   (clk),
            .rst_l (rst_l),
            .held  (held[i]),
            .pulse (pulses[i])
        );
    end

endmodule

`default_nettype wire

// File: src/action_arbiter.sv
`default_nettype none
`timescale 1ns/100ps

module action_arbiter (
    input  logic                    clk,
    input  logic                    rst_l,
    input  tetris_pkg::action_vec_t pulses,
    input  tetris_pkg::screen_t     screen,
    input  logic                    act_ack,
    output logic                    act_req,
    output tetris_pkg::action_t     act_code
);

    typedef enum logic [1:0] {
        st_idle,
        st_req,
        st_release
    } state_t;

    state_t                  state;
    tetris_pkg::action_vec_t pending;
    tetris_pkg::action_vec_t grant;
    tetris_pkg::action_vec_t clear_mask;
    tetris_pkg::action_t     sel_code;
    logic                    running;
    logic                    start_req;

    assign running = (screen == tetris_pkg::scr_sprint);

    // fixed priority, lowest bit first
    always_comb begin
        sel_code = tetris_pkg::act_none;
        grant    = '0;
        for (int i = tetris_pkg::num_actions - 1; i >= 0; i--) begin
            if (pending[i]) begin
                sel_code = tetris_pkg::action_t'(i + 1);
                grant    = tetris_pkg::action_vec_t'(1) << i;
            end
        end
    end

    assign start_req  = (state == st_idle) && running && (pending != '0);
    assign clear_mask = start_req ? grant : '0;

    // repeats of a pending action merge into its bit
    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            pending <= '0;
        end else if (!running) begin
            pending <= '0;
        end else begin
            pending <= (pending & ~clear_mask) | pulses;
        end
    end

    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (start_req) begin
                        state <= st_req;
                    end
                end
                st_req: begin
                    if (act_ack) begin
                        state <= st_release;
                    end
                end
                // wait for the engine to drop ack before the next request
                st_release: begin
                    if (!act_ack) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_req) begin
            act_code <= sel_code;
        end
    end

    assign act_req = (state == st_req);

endmodule

`default_nettype wire

// File: src/screen_fsm.sv
`default_nettype none
`timescale 1ns/100ps

module screen_fsm #(
    parameter int SPRINT_LINES = tetris_pkg::sprint_lines_default
) (
    input  logic                clk,
    input  logic                rst_l,
    input  logic                start_press,
    input  logic                line_clear,
    input  logic [2:0]          lines_add,
    input  logic                top_out,
    output tetris_pkg::screen_t screen,
    output logic                game_start,
    output tetris_pkg::lines_t  lines_cleared
);

    logic [6:0]         lines_sum;
    tetris_pkg::lines_t lines_next;
    logic               target_hit;

    assign lines_sum = {1'b0, lines_cleared} + {4'b0, lines_add};

    // saturate at 63
    assign lines_next = lines_sum[6] ? '1 : lines_sum[5:0];

    assign target_hit = line_clear && (lines_next >= SPRINT_LINES);

    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            screen        <= tetris_pkg::scr_title;
            game_start    <= 1'b0;
            lines_cleared <= '0;
        end else begin
            game_start <= 1'b0;
            case (screen)
                tetris_pkg::scr_title: begin
                    if (start_press) begin
                        screen        <= tetris_pkg::scr_sprint;
                        game_start    <= 1'b1;
                        lines_cleared <= '0;
                    end
                end
                tetris_pkg::scr_sprint: begin
                    if (line_clear) begin
                        lines_cleared <= lines_next;
                    end
                    if (top_out || target_hit) begin
                        screen <= tetris_pkg::scr_end;
                    end
                end
                tetris_pkg::scr_end: begin
                    if (start_press) begin
                        screen <= tetris_pkg::scr_title;
                    end
                end
                default: begin
                    screen <= tetris_pkg::scr_title;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: src/sprint_timer.sv
`default_nettype none
`timescale 1ns/100ps

module sprint_timer #(
    parameter int TICK_CYCLES = tetris_pkg::tick_cycles_default
) (
    input  logic                   clk,
    input  logic                   rst_l,
    input  tetris_pkg::screen_t    screen,
    input  logic                   game_start,
    output tetris_pkg::play_time_t play_time
);

    localparam int DIV_W = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;

    logic [DIV_W-1:0] div;
    logic             running;
    logic             tick;
    logic             ms_en;
    logic             cs_en;
    logic             ds_en;
    logic             sec_en;
    logic             min_en;
    logic             hr_en;

    function automatic logic [5:0] next_digit(input logic [5:0] val, input logic [5:0] last);
        return (val == last) ? 6'd0 : val + 6'd1;
    endfunction

    assign running = (screen == tetris_pkg::scr_sprint);
    assign tick    = running && (div == DIV_W'(TICK_CYCLES - 1));

    // carry chain, each digit enables the next at its terminal value
    assign ms_en  = tick;
    assign cs_en  = ms_en && (play_time.milliseconds == 4'd9);
    assign ds_en  = cs_en && (play_time.centiseconds == 4'd9);
    assign sec_en = ds_en && (play_time.deciseconds == 4'd9);
    assign min_en = sec_en && (play_time.seconds == 6'd59);
    assign hr_en  = min_en && (play_time.minutes == 6'd59);

    // the game_start cycle already counts as the first divider cycle
    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            div <= '0;
        end else if (game_start) begin
            div <= DIV_W'(1);
        end else if (tick) begin
            div <= '0;
        end else if (running) begin
            div <= div + 1'b1;
        end
    end

    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            play_time <= '0;
        end else if (game_start) begin
            play_time <= '0;
        end else begin
            if (ms_en) begin
                play_time.milliseconds <= 4'(next_digit({2'b0, play_time.milliseconds}, 6'd9));
            end
            if (cs_en) begin
                play_time.centiseconds <= 4'(next_digit({2'b0, play_time.centiseconds}, 6'd9));
            end
            if (ds_en) begin
                play_time.deciseconds <= 4'(next_digit({2'b0, play_time.deciseconds}, 6'd9));
            end
            if (sec_en) begin
                play_time.seconds <= next_digit(play_time.seconds, 6'd59);
            end
            if (min_en) begin
                play_time.minutes <= next_digit(play_time.minutes, 6'd59);
            end
            // hours just wrap
            if (hr_en) begin
                play_time.hours <= play_time.hours + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/tetris_sprint_top.sv
`default_nettype none
`timescale 1ns/100ps

module tetris_sprint_top #(
    parameter int DAS_DELAY    = tetris_pkg::das_delay_default,
    parameter int ARR_PERIOD   = tetris_pkg::arr_period_default,
    parameter int TICK_CYCLES  = tetris_pkg::tick_cycles_default,
    parameter int SPRINT_LINES = tetris_pkg::sprint_lines_default
) (
    input  logic                   clk,
    input  logic                   rst_l,
    input  tetris_pkg::buttons_t   buttons,
    input  logic                   line_clear,
    input  logic [2:0]             lines_add,
    input  logic                   top_out,
    input  logic                   act_ack,
    output logic                   act_req,
    output tetris_pkg::action_t    act_code,
    output tetris_pkg::screen_t    screen,
    output tetris_pkg::lines_t     lines_cleared,
    output tetris_pkg::play_time_t play_time
);

    tetris_pkg::action_vec_t pulses;
    logic                    start_press;
    logic                    game_start;

    action_inputs #(
        .DAS_DELAY  (DAS_DELAY),
        .ARR_PERIOD (ARR_PERIOD)
    ) u_inputs (
        .clk         (clk),
        .rst_l       (rst_l),
        .buttons     (buttons),
        .pulses      (pulses),
        .start_press (start_press)
    );

    action_arbiter u_arbiter (
        .clk      (clk),
        .rst_l    (rst_l),
        .pulses   (pulses),
        .screen   (screen),
        .act_ack  (act_ack),
        .act_req  (act_req),
        .act_code (act_code)
    );

    screen_fsm #(
        .SPRINT_LINES (SPRINT_LINES)
    ) u_screen (
        .clk           (clk),
        .rst_l         (rst_l),
        .start_press   (start_press),
        .line_clear    (line_clear),
        .lines_add     (lines_add),
        .top_out       (top_out),
        .screen        (screen),
        .game_start    (game_start),
        .lines_cleared (lines_cleared)
    );

    sprint_timer #(
        .TICK_CYCLES (TICK_CYCLES)
    ) u_timer (
        .clk        (clk),
        .rst_l      (rst_l),
        .screen     (screen),
        .game_start (game_start),
        .play_time  (play_time)
    );

endmodule

`default_nettype wire

// File: testbench/tb_tetris_sprint.sv
`default_nettype none
`timescale 1ns/100ps

module tb_tetris_sprint;

    localparam int DAS_DELAY    = 10;
    localparam int ARR_PERIOD   = 8;
    localparam int TICK_CYCLES  = 3;
    localparam int SPRINT_LINES = 12;

    logic                   clk;
    logic                   rst_l;
    tetris_pkg::buttons_t   buttons;
    logic                   line_clear;
    logic [2:0]             lines_add;
    logic                   top_out;
    logic                   act_ack;
    logic                   act_req;
    tetris_pkg::action_t    act_code;
    tetris_pkg::screen_t    screen;
    tetris_pkg::lines_t     lines_cleared;
    tetris_pkg::play_time_t play_time;

    int                  seed;
    int                  errors;
    int                  err_mark;
    int                  tests_run;
    int                  tests_failed;
    int                  cyc;
    int                  loops;
    logic                req_seen;
    tetris_pkg::action_t ack_log[$];
    tetris_pkg::action_t exp_codes[$];

    // reference model state
    tetris_pkg::screen_t model_screen;
    int                  model_lines;
    int                  start_cyc;
    int                  end_cyc;

    tetris_sprint_top #(
        .DAS_DELAY    (DAS_DELAY),
        .ARR_PERIOD   (ARR_PERIOD),
        .TICK_CYCLES  (TICK_CYCLES),
        .SPRINT_LINES (SPRINT_LINES)
    ) dut0 (
        .clk           (clk),
        .rst_l         (rst_l),
        .buttons       (buttons),
        .line_clear    (line_clear),
        .lines_add     (lines_add),
        .top_out       (top_out),
        .act_ack       (act_ack),
        .act_req       (act_req),
        .act_code      (act_code),
        .screen        (screen),
        .lines_cleared (lines_cleared),
        .play_time     (play_time)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // piece engine, ack follows req one cycle later in both directions
    always begin
        @(posedge clk);
        #2;
        if (act_req && !req_seen && act_ack) begin
            $display("act_req rose while act_ack was still high");
            errors++;
        end
        if (req_seen && act_req && !act_ack) begin
            act_ack = 1'b1;
            ack_log.push_back(act_code);
        end else if (!req_seen && !act_req && act_ack) begin
            act_ack = 1'b0;
        end
        req_seen = act_req;
    end

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    function automatic tetris_pkg::play_time_t time_digits(input int ms);
        tetris_pkg::play_time_t t;
        t.milliseconds = 4'(ms % 10);
        t.centiseconds = 4'((ms / 10) % 10);
        t.deciseconds  = 4'((ms / 100) % 10);
        t.seconds      = 6'((ms / 1000) % 60);
        t.minutes      = 6'((ms / 60000) % 60);
        t.hours        = 5'((ms / 3600000) % 32);
        return t;
    endfunction

    // whole tick periods from game start to now, or to the end of the sprint
    function automatic int sprint_ms();
        int last;
        last = (model_screen == tetris_pkg::scr_sprint) ? cyc : end_cyc;
        return (last - start_cyc) / TICK_CYCLES;
    endfunction

    function automatic int expected_pulses(input int hold, input bit repeat_en);
        int n;
        n = 1;
        if (repeat_en && hold > DAS_DELAY) begin
            n = n + 1 + (hold - 1 - DAS_DELAY) / ARR_PERIOD;
        end
        return n;
    endfunction

    task automatic step(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_action(input string name, input tetris_pkg::action_t got,
                                input tetris_pkg::action_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_screen(input string name, input tetris_pkg::screen_t got,
                                input tetris_pkg::screen_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_lines(input string name, input tetris_pkg::lines_t got,
                               input tetris_pkg::lines_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_play_time(input string name, input tetris_pkg::play_time_t got,
                                   input tetris_pkg::play_time_t exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    // compare the codes logged since base with exp_codes
    task automatic check_codes(input int base);
        check_count("ack count", ack_log.size() - base, exp_codes.size());
        for (int i = 0; i < exp_codes.size() && base + i < ack_log.size(); i++) begin
            check_action("act_code", ack_log[base + i], exp_codes[i]);
        end
    endtask

    // act_req low for 8 cycles in a row means the engine is idle
    task automatic wait_quiet(input string what);
        int quiet;
        int n;
        quiet = 0;
        n = 0;
        while (quiet < 8 && n < 300) begin
            step(1);
            quiet = act_req ? 0 : quiet + 1;
            n++;
        end
        if (quiet < 8) begin
            $display("timeout while waiting for %s to finish", what);
            errors++;
        end
    endtask

    task automatic set_key(input int key, input logic val);
        case (key)
            0: buttons.key_left = val;
            1: buttons.key_right = val;
            2: buttons.key_soft = val;
            default: buttons.key_hard = val;
        endcase
    endtask

    // 2 sync cycles, then the screen moves on the next edge
    task automatic press_start(input tetris_pkg::screen_t next);
        buttons.key_start = 1'b0;
        step(3);
        model_screen = next;
        check_screen("screen", screen, next);
        buttons.key_start = 1'b1;
        if (next == tetris_pkg::scr_sprint) begin
            start_cyc   = cyc;
            model_lines = 0;
        end
    endtask

    task automatic hold_action(input int key, input bit rot, input int hold);
        tetris_pkg::action_t code;
        int                  base;
        case (key)
            0: code = rot ? tetris_pkg::act_rotate_l : tetris_pkg::act_move_l;
            1: code = rot ? tetris_pkg::act_rotate_r : tetris_pkg::act_move_r;
            2: code = tetris_pkg::act_soft_drop;
            default: code = tetris_pkg::act_hard_drop;
        endcase
        buttons.rotate_mode = rot;
        wait_quiet("earlier requests");
        base = ack_log.size();
        set_key(key, 1'b0);
        step(hold);
        set_key(key, 1'b1);
        step(4);
        wait_quiet("auto shift requests");
        exp_codes.delete();
        repeat (expected_pulses(hold, key != 3)) begin
            exp_codes.push_back(code);
        end
        check_codes(base);
    endtask

    // mask bits are left, right, soft, hard from bit 0 up
    task automatic press_combo(input logic [3:0] mask, input bit rot);
        int base;
        buttons.rotate_mode = rot;
        wait_quiet("earlier requests");
        base = ack_log.size();
        for (int k = 0; k < 4; k++) begin
            if (mask[k]) begin
                set_key(k, 1'b0);
            end
        end
        step(3);
        for (int k = 0; k < 4; k++) begin
            set_key(k, 1'b1);
        end
        step(4);
        wait_quiet("priority requests");
        exp_codes.delete();
        if (mask[3]) exp_codes.push_back(tetris_pkg::act_hard_drop);
        if (mask[2]) exp_codes.push_back(tetris_pkg::act_soft_drop);
        if (mask[1] && !rot) exp_codes.push_back(tetris_pkg::act_move_r);
        if (mask[0] && !rot) exp_codes.push_back(tetris_pkg::act_move_l);
        if (mask[1] && rot) exp_codes.push_back(tetris_pkg::act_rotate_r);
        if (mask[0] && rot) exp_codes.push_back(tetris_pkg::act_rotate_l);
        check_codes(base);
    endtask

    task automatic clear_lines(input int add);
        line_clear = 1'b1;
        lines_add  = 3'(add);
        step(1);
        line_clear = 1'b0;
        lines_add  = 3'd0;
        model_lines = (model_lines + add > 63) ? 63 : model_lines + add;
        if (model_screen == tetris_pkg::scr_sprint && model_lines >= SPRINT_LINES) begin
            model_screen = tetris_pkg::scr_end;
            end_cyc      = cyc;
        end
        check_lines("lines_cleared", lines_cleared, 6'(model_lines));
        check_screen("screen", screen, model_screen);
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == err_mark) begin
            $display("test %0d %s: pass", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL with %0d errors", tests_run, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        seed         = 97798;
        errors       = 0;
        err_mark     = 0;
        tests_run    = 0;
        tests_failed = 0;
        cyc          = 0;
        clk          = 1'b0;
        rst_l        = 1'b0;
        buttons      = '1;
        line_clear   = 1'b0;
        lines_add    = 3'd0;
        top_out      = 1'b0;
        act_ack      = 1'b0;
        req_seen     = 1'b0;
        model_screen = tetris_pkg::scr_title;
        model_lines  = 0;
        start_cyc    = 0;
        end_cyc      = 0;
        repeat (5) @(posedge clk);
        #2;
        rst_l = 1'b1;
        step(2);

        check_bit("act_req", act_req, 1'b0);
        check_screen("screen", screen, tetris_pkg::scr_title);
        check_lines("lines_cleared", lines_cleared, '0);
        check_play_time("play_time", play_time, '0);
        buttons.key_hard = 1'b0;
        buttons.key_left = 1'b0;
        step(20);
        buttons = '1;
        step(12);
        check_count("ack count", ack_log.size(), 0);
        check_screen("screen", screen, tetris_pkg::scr_title);
        finish_test("reset state");

        // run past the first seconds carry
        press_start(tetris_pkg::scr_sprint);
        while (cyc - start_cyc < 3300) begin
            step(rand_range(1, 150));
            check_play_time("play_time", play_time, time_digits(sprint_ms()));
        end
        finish_test("start and clock");

        for (int i = 0; i < 8; i++) begin
            hold_action(rand_range(0, 2), rand_range(0, 1), rand_range(1, 60));
        end
        for (int i = 0; i < 3; i++) begin
            hold_action(3, rand_range(0, 1), rand_range(1, 60));
        end
        finish_test("auto shift");

        for (int i = 0; i < 6; i++) begin
            press_combo(4'(rand_range(1, 15)), rand_range(0, 1));
        end
        finish_test("priority");

        wait_quiet("earlier requests");
        loops = 0;
        while (model_screen == tetris_pkg::scr_sprint && loops < 40) begin
            step(rand_range(1, 6));
            clear_lines(rand_range(1, 4));
            loops++;
        end
        check_play_time("play_time", play_time, time_digits(sprint_ms()));
        step(rand_range(20, 60));
        check_play_time("play_time", play_time, time_digits(sprint_ms()));
        loops = ack_log.size();
        buttons.key_soft = 1'b0;
        buttons.key_hard = 1'b0;
        step(20);
        buttons = '1;
        step(10);
        check_count("ack count", ack_log.size() - loops, 0);
        finish_test("sprint end");

        // second game ends by top out
        press_start(tetris_pkg::scr_title);
        step(4);
        press_start(tetris_pkg::scr_sprint);
        step(rand_range(2, 10));
        clear_lines(rand_range(1, 4));
        step(rand_range(2, 10));
        clear_lines(rand_range(1, 4));
        step(rand_range(5, 30));
        top_out = 1'b1;
        step(1);
        top_out      = 1'b0;
        model_screen = tetris_pkg::scr_end;
        end_cyc      = cyc;
        check_screen("screen", screen, tetris_pkg::scr_end);
        check_lines("lines_cleared", lines_cleared, 6'(model_lines));
        check_play_time("play_time", play_time, time_digits(sprint_ms()));
        step(15);
        check_play_time("play_time", play_time, time_digits(sprint_ms()));
        finish_test("top out");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
src/tetris_pkg.sv
src/action_repeat.sv
src/action_inputs.sv
src/action_arbiter.sv
src/screen_fsm.sv
src/sprint_timer.sv
src/tetris_sprint_top.sv
testbench/tb_tetris_sprint.sv
